//--- hw/cpu_axi_settings.svh
`ifndef CPU_AXI_SETTINGS_SVH
`define CPU_AXI_SETTINGS_SVH

// bus widths
`define AXI_DATA_W      64
`define AXI_ADDR_W      32
`define AXI_ID_W        4
`define AXI_LEN_W       8
`define AXI_STRB_W      (`AXI_DATA_W / 8)

// one outstanding burst per channel, so fixed IDs
`define RD_ID           4'd0
`define WR_ID           4'd1

`define BEAT_SIZE_8B    3'd3    // 8 bytes per read beat
`define AXI_BURST_INCR  2'b01

`endif

//--- hw/cpu_axi_pkg.sv
package cpu_axi_pkg;

    // owner of the shared read path
    typedef enum logic [1:0] {
        GRANT_NONE = 2'd0,
        GRANT_MEMR = 2'd1,
        GRANT_IF   = 2'd2
    } grant_e;

    // read engine
    typedef enum logic [1:0] {
        RD_IDLE = 2'd0,
        RD_ADDR = 2'd1,     // arvalid up
        RD_DATA = 2'd2      // collecting R beats
    } rd_state_e;

    // write engine
    typedef enum logic [1:0] {
        WR_IDLE = 2'd0,
        WR_ADDR = 2'd1,     // awvalid up
        WR_DATA = 2'd2,     // W beats
        WR_RESP = 2'd3      // waiting for B
    } wr_state_e;

endpackage

//--- hw/axi_rw_if.sv
`timescale 1ns/1ps
`include "cpu_axi_settings.svh"

interface axi_rw_if;

    // granted read request
    logic                   r_valid;
    logic                   r_ready;    // one per data beat
    logic [`AXI_ADDR_W-1:0] r_addr;
    logic [`AXI_LEN_W-1:0]  r_len;
    logic [`AXI_DATA_W-1:0] r_data;
    logic                   r_last;

    // write request
    logic                   w_valid;
    logic                   w_ready;    // one per accepted W beat
    logic [`AXI_ADDR_W-1:0] w_addr;
    logic [`AXI_LEN_W-1:0]  w_len;
    logic [2:0]             w_size;
    logic [`AXI_DATA_W-1:0] w_data;
    logic                   w_last;     // pulse on B

    modport arb (
        output r_valid, r_addr, r_len, w_valid, w_addr, w_len, w_size, w_data,
        input  r_ready, r_data, r_last, w_ready, w_last
    );

    modport rd_mst (
        input  r_valid, r_addr, r_len,
        output r_ready, r_data, r_last
    );

    modport wr_mst (
        input  w_valid, w_addr, w_len, w_size, w_data,
        output w_ready, w_last
    );

endinterface

//--- hw/mem_bus_arbiter.sv
`timescale 1ns/1ps
`include "cpu_axi_settings.svh"

module mem_bus_arbiter
    import cpu_axi_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,

    // fetch read port
    input  logic                   if_ar_valid_i,
    input  logic [`AXI_ADDR_W-1:0] if_ar_addr_i,
    input  logic [`AXI_LEN_W-1:0]  if_ar_len_i,
    output logic                   if_ar_ready_o,
    output logic [`AXI_DATA_W-1:0] if_ar_data_o,
    output logic                   if_ar_last_o,

    // load/store read port
    input  logic                   mem_r_valid_i,
    input  logic [`AXI_ADDR_W-1:0] mem_r_addr_i,
    input  logic [`AXI_LEN_W-1:0]  mem_r_len_i,
    output logic                   mem_r_ready_o,
    output logic [`AXI_DATA_W-1:0] mem_r_data_o,
    output logic                   mem_r_last_o,

    // load/store write port
    input  logic                   mem_w_valid_i,
    input  logic [`AXI_ADDR_W-1:0] mem_w_addr_i,
    input  logic [`AXI_LEN_W-1:0]  mem_w_len_i,
    input  logic [2:0]             mem_w_size_i,
    input  logic [`AXI_DATA_W-1:0] mem_w_data_i,
    output logic                   mem_w_ready_o,
    output logic                   mem_w_last_o,

    axi_rw_if.arb                  bus
);

    grant_e grant_q;
    grant_e grant_d;
    logic   grant_mem;
    logic   grant_if;

    always_ff @(posedge clk) begin
        if (rst) begin
            grant_q <= GRANT_NONE;
        end else begin
            grant_q <= grant_d;
        end
    end

    always_comb begin
        grant_d = grant_q;
        case (grant_q)
            GRANT_NONE: begin
                if (mem_r_valid_i) begin    // MEM wins a tie
                    grant_d = GRANT_MEMR;
                end else if (if_ar_valid_i) begin
                    grant_d = GRANT_IF;
                end
            end
            GRANT_MEMR, GRANT_IF: begin
                // burst done, or requester gave up
                if ((bus.r_ready && bus.r_last) || !bus.r_valid) begin
                    grant_d = GRANT_NONE;
                end
            end
            default: grant_d = GRANT_NONE;
        endcase
    end

    assign grant_mem = (grant_q == GRANT_MEMR);
    assign grant_if  = (grant_q == GRANT_IF);

    // request mux onto the shared read path
    assign bus.r_valid = (grant_mem && mem_r_valid_i) || (grant_if && if_ar_valid_i);
    assign bus.r_addr  = grant_mem ? mem_r_addr_i :
                         grant_if  ? if_ar_addr_i : '0;
    assign bus.r_len   = grant_mem ? mem_r_len_i :
                         grant_if  ? if_ar_len_i  : '0;

    // only the owner sees the response
    assign mem_r_ready_o = grant_mem ? bus.r_ready : 1'b0;
    assign mem_r_data_o  = grant_mem ? bus.r_data  : '0;
    assign mem_r_last_o  = grant_mem ? bus.r_last  : 1'b0;
    assign if_ar_ready_o = grant_if  ? bus.r_ready : 1'b0;
    assign if_ar_data_o  = grant_if  ? bus.r_data  : '0;
    assign if_ar_last_o  = grant_if  ? bus.r_last  : 1'b0;

    // single writer, no arbitration
    assign bus.w_valid    = mem_w_valid_i;
    assign bus.w_addr     = mem_w_addr_i;
    assign bus.w_len      = mem_w_len_i;
    assign bus.w_size     = mem_w_size_i;
    assign bus.w_data     = mem_w_data_i;
    assign mem_w_ready_o  = bus.w_ready;
    assign mem_w_last_o   = bus.w_last;

endmodule

//--- hw/axi_read_master.sv
`timescale 1ns/1ps
`include "cpu_axi_settings.svh"

module axi_read_master
    import cpu_axi_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,

    axi_rw_if.rd_mst               bus,

    // AR channel
    output logic [`AXI_ADDR_W-1:0] araddr_o,
    output logic [`AXI_LEN_W-1:0]  arlen_o,
    output logic [2:0]             arsize_o,
    output logic [1:0]             arburst_o,
    output logic [`AXI_ID_W-1:0]   arid_o,
    output logic                   arvalid_o,
    input  logic                   arready_i,

    // R channel
    input  logic [`AXI_DATA_W-1:0] rdata_i,
    input  logic                   rlast_i,
    input  logic                   rvalid_i,
    output logic                   rready_o
);

    rd_state_e              state_q;
    rd_state_e              state_d;
    logic [`AXI_ADDR_W-1:0] addr_q;
    logic [`AXI_LEN_W-1:0]  len_q;
    logic                   beat;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= RD_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // latch request on acceptance
    always_ff @(posedge clk) begin
        if (state_q == RD_IDLE && bus.r_valid) begin
            addr_q <= bus.r_addr;
            len_q  <= bus.r_len;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            RD_IDLE: if (bus.r_valid) state_d = RD_ADDR;
            RD_ADDR: if (arready_i)   state_d = RD_DATA;
            RD_DATA: if (rvalid_i && rlast_i) state_d = RD_IDLE;
            default: state_d = RD_IDLE;
        endcase
    end

    assign araddr_o  = addr_q;
    assign arlen_o   = len_q;
    assign arsize_o  = `BEAT_SIZE_8B;   // always full-width beats
    assign arburst_o = `AXI_BURST_INCR;
    assign arid_o    = `RD_ID;
    assign arvalid_o = (state_q == RD_ADDR);

    // core side never stalls
    assign rready_o  = (state_q == RD_DATA);
    assign beat      = rready_o && rvalid_i;

    assign bus.r_ready = beat;
    assign bus.r_last  = beat && rlast_i;
    assign bus.r_data  = rdata_i;

endmodule

//--- hw/axi_write_master.sv
`timescale 1ns/1ps
`include "cpu_axi_settings.svh"

module axi_write_master
    import cpu_axi_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,

    axi_rw_if.wr_mst               bus,

    // AW channel
    output logic [`AXI_ADDR_W-1:0] awaddr_o,
    output logic [`AXI_LEN_W-1:0]  awlen_o,
    output logic [2:0]             awsize_o,
    output logic [1:0]             awburst_o,
    output logic [`AXI_ID_W-1:0]   awid_o,
    output logic                   awvalid_o,
    input  logic                   awready_i,

    // W channel
    output logic [`AXI_DATA_W-1:0] wdata_o,
    output logic [`AXI_STRB_W-1:0] wstrb_o,
    output logic                   wlast_o,
    output logic                   wvalid_o,
    input  logic                   wready_i,

    // B channel
    input  logic                   bvalid_i,
    output logic                   bready_o
);

    wr_state_e              state_q;
    wr_state_e              state_d;
    logic [`AXI_ADDR_W-1:0] addr_q;
    logic [`AXI_LEN_W-1:0]  len_q;
    logic [2:0]             size_q;
    logic [`AXI_LEN_W-1:0]  beat_cnt_q;
    logic [2:0]             lane_q;     // byte offset of current beat
    logic [3:0]             lane_step;  // bytes per beat
    logic [`AXI_STRB_W-1:0] lane_mask;
    logic                   w_beat;

    assign w_beat    = wvalid_o && wready_i;
    assign lane_step = 4'd1 << size_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= WR_IDLE;
            beat_cnt_q <= '0;
            lane_q     <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == WR_ADDR && awready_i) begin
                beat_cnt_q <= '0;
                lane_q     <= addr_q[2:0];
            end else if (w_beat) begin
                beat_cnt_q <= beat_cnt_q + 1'b1;
                lane_q     <= lane_q + lane_step[2:0];  // wraps within the word
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == WR_IDLE && bus.w_valid) begin
            addr_q <= bus.w_addr;
            len_q  <= bus.w_len;
            size_q <= bus.w_size;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            WR_IDLE: if (bus.w_valid) state_d = WR_ADDR;
            WR_ADDR: if (awready_i)   state_d = WR_DATA;
            WR_DATA: if (w_beat && wlast_o) state_d = WR_RESP;
            WR_RESP: if (bvalid_i)    state_d = WR_IDLE;
            default: state_d = WR_IDLE;
        endcase
    end

    assign awaddr_o  = addr_q;
    assign awlen_o   = len_q;
    assign awsize_o  = size_q;
    assign awburst_o = `AXI_BURST_INCR;
    assign awid_o    = `WR_ID;
    assign awvalid_o = (state_q == WR_ADDR);

    // 2^size low lanes, moved up to the beat offset
    assign lane_mask = ~({`AXI_STRB_W{1'b1}} << lane_step);
    assign wstrb_o   = lane_mask << lane_q;

    assign wdata_o   = bus.w_data;      // requester advances data after each w_ready
    assign wvalid_o  = (state_q == WR_DATA);
    assign wlast_o   = (beat_cnt_q == len_q);
    assign bready_o  = (state_q == WR_RESP);

    assign bus.w_ready = w_beat;
    assign bus.w_last  = bready_o && bvalid_i;

endmodule

//--- hw/cpu_axi_top.sv
`timescale 1ns/1ps
`include "cpu_axi_settings.svh"

module cpu_axi_top (
    input  logic                   clk,
    input  logic                   rst,

    // fetch read
    input  logic                   if_ar_valid_i,
    input  logic [`AXI_ADDR_W-1:0] if_ar_addr_i,
    input  logic [`AXI_LEN_W-1:0]  if_ar_len_i,
    output logic                   if_ar_ready_o,
    output logic [`AXI_DATA_W-1:0] if_ar_data_o,
    output logic                   if_ar_last_o,

    // load/store read
    input  logic                   mem_r_valid_i,
    input  logic [`AXI_ADDR_W-1:0] mem_r_addr_i,
    input  logic [`AXI_LEN_W-1:0]  mem_r_len_i,
    output logic                   mem_r_ready_o,
    output logic [`AXI_DATA_W-1:0] mem_r_data_o,
    output logic                   mem_r_last_o,

    // load/store write
    input  logic                   mem_w_valid_i,
    input  logic [`AXI_ADDR_W-1:0] mem_w_addr_i,
    input  logic [`AXI_LEN_W-1:0]  mem_w_len_i,
    input  logic [2:0]             mem_w_size_i,
    input  logic [`AXI_DATA_W-1:0] mem_w_data_i,
    output logic                   mem_w_ready_o,
    output logic                   mem_w_last_o,

    // AXI4 read
    output logic [`AXI_ADDR_W-1:0] araddr_o,
    output logic [`AXI_LEN_W-1:0]  arlen_o,
    output logic [2:0]             arsize_o,
    output logic [1:0]             arburst_o,
    output logic [`AXI_ID_W-1:0]   arid_o,
    output logic                   arvalid_o,
    input  logic                   arready_i,
    input  logic [`AXI_DATA_W-1:0] rdata_i,
    input  logic                   rlast_i,
    input  logic                   rvalid_i,
    output logic                   rready_o,

    // AXI4 write
    output logic [`AXI_ADDR_W-1:0] awaddr_o,
    output logic [`AXI_LEN_W-1:0]  awlen_o,
    output logic [2:0]             awsize_o,
    output logic [1:0]             awburst_o,
    output logic [`AXI_ID_W-1:0]   awid_o,
    output logic                   awvalid_o,
    input  logic                   awready_i,
    output logic [`AXI_DATA_W-1:0] wdata_o,
    output logic [`AXI_STRB_W-1:0] wstrb_o,
    output logic                   wlast_o,
    output logic                   wvalid_o,
    input  logic                   wready_i,
    input  logic                   bvalid_i,
    output logic                   bready_o
);

    axi_rw_if bus ();

    // core ports map one to one
    mem_bus_arbiter u_arbiter (
        .bus (bus.arb),
        .*
    );

    axi_read_master u_rd_master (
        .bus (bus.rd_mst),
        .*
    );

    axi_write_master u_wr_master (
        .bus (bus.wr_mst),
        .*
    );

endmodule

//--- verif/axi_mem_model.sv
`timescale 1ns/1ps
`include "cpu_axi_settings.svh"

module axi_mem_model (
    input  logic                   clk,
    input  logic [`AXI_ADDR_W-1:0] araddr_o,
    input  logic [`AXI_LEN_W-1:0]  arlen_o,
    input  logic                   arvalid_o,
    output logic                   arready_i,
    output logic [`AXI_DATA_W-1:0] rdata_i,
    output logic                   rlast_i,
    output logic                   rvalid_i,
    input  logic [`AXI_ADDR_W-1:0] awaddr_o,
    input  logic [`AXI_LEN_W-1:0]  awlen_o,
    input  logic [2:0]             awsize_o,
    input  logic                   awvalid_o,
    output logic                   awready_i,
    input  logic [`AXI_DATA_W-1:0] wdata_o,
    input  logic [`AXI_STRB_W-1:0] wstrb_o,
    input  logic                   wvalid_o,
    output logic                   wready_i,
    output logic                   bvalid_i
);

    logic [63:0] mem [int];

    function automatic logic [63:0] word_at(int idx);
        logic [31:0] a;
        a = idx << 3;
        return mem.exists(idx) ? mem[idx] : {~a, a};
    endfunction

    // 0 to 3 idle cycles
    task automatic idle_gap();
        repeat ($urandom % 4) begin
            @(posedge clk);
            #2;
        end
    endtask

    initial begin
        logic [31:0] addr;
        int          len;
        {arready_i, rvalid_i, rlast_i} = '0;
        rdata_i = '0;
        forever begin
            @(posedge clk);
            #2;
            while (arvalid_o !== 1'b1) begin
                @(posedge clk);
                #2;
            end
            idle_gap();
            arready_i = 1'b1;
            addr = araddr_o;
            len  = arlen_o;
            @(posedge clk);
            #2 arready_i = 1'b0;
            for (int i = 0; i <= len; i++) begin
                idle_gap();
                rvalid_i = 1'b1;    // rready stays high during the burst
                rdata_i  = word_at((addr >> 3) + i);
                rlast_i  = (i == len);
                @(posedge clk);
                #2 {rvalid_i, rlast_i} = 2'b00;
            end
        end
    end

    initial begin
        logic [31:0] addr, baddr;
        logic [2:0]  size;
        logic [63:0] w;
        int          len;
        {awready_i, wready_i, bvalid_i} = '0;
        forever begin
            @(posedge clk);
            #2;
            while (awvalid_o !== 1'b1) begin
                @(posedge clk);
                #2;
            end
            idle_gap();
            awready_i = 1'b1;
            addr = awaddr_o;
            len  = awlen_o;
            size = awsize_o;
            @(posedge clk);
            #2 awready_i = 1'b0;
            for (int i = 0; i <= len; i++) begin
                idle_gap();
                while (wvalid_o !== 1'b1) begin
                    @(posedge clk);
                    #2;
                end
                wready_i = 1'b1;
                baddr = addr + (i << size);
                w = word_at(baddr >> 3);
                for (int b = 0; b < 8; b++) begin
                    if (wstrb_o[b]) w[b*8 +: 8] = wdata_o[b*8 +: 8];
                end
                @(posedge clk);
                #2 wready_i = 1'b0;
                mem[baddr >> 3] = w;
            end
            idle_gap();
            bvalid_i = 1'b1;
            @(posedge clk);
            #2 bvalid_i = 1'b0;
        end
    end

endmodule

//--- verif/tb_checker.sv
`timescale 1ns/1ps
`include "cpu_axi_settings.svh"

module tb_checker (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   if_ar_valid_i,
    input  logic [`AXI_ADDR_W-1:0] if_ar_addr_i,
    input  logic [`AXI_LEN_W-1:0]  if_ar_len_i,
    input  logic                   if_ar_ready_o,
    input  logic [`AXI_DATA_W-1:0] if_ar_data_o,
    input  logic                   if_ar_last_o,
    input  logic                   mem_r_valid_i,
    input  logic [`AXI_ADDR_W-1:0] mem_r_addr_i,
    input  logic [`AXI_LEN_W-1:0]  mem_r_len_i,
    input  logic                   mem_r_ready_o,
    input  logic [`AXI_DATA_W-1:0] mem_r_data_o,
    input  logic                   mem_r_last_o,
    input  logic                   mem_w_valid_i,
    input  logic [`AXI_ADDR_W-1:0] mem_w_addr_i,
    input  logic [`AXI_LEN_W-1:0]  mem_w_len_i,
    input  logic [2:0]             mem_w_size_i,
    input  logic [`AXI_DATA_W-1:0] mem_w_data_i,
    input  logic                   mem_w_ready_o,
    input  logic                   mem_w_last_o,
    input  logic [`AXI_ADDR_W-1:0] araddr_o,
    input  logic [`AXI_LEN_W-1:0]  arlen_o,
    input  logic [2:0]             arsize_o,
    input  logic [1:0]             arburst_o,
    input  logic [`AXI_ID_W-1:0]   arid_o,
    input  logic                   arvalid_o,
    input  logic                   arready_i,
    input  logic [`AXI_ADDR_W-1:0] awaddr_o,
    input  logic [`AXI_LEN_W-1:0]  awlen_o,
    input  logic [2:0]             awsize_o,
    input  logic [1:0]             awburst_o,
    input  logic [`AXI_ID_W-1:0]   awid_o,
    input  logic                   awvalid_o,
    input  logic                   awready_i,
    input  logic                   wvalid_o,
    input  logic                   wlast_o,
    input  logic [`AXI_STRB_W-1:0] wstrb_o,
    input  logic                   bready_o,
    input  logic                   rready_o,
    input  logic                   test_done_i,
    input  int                     test_idx_i,
    input  int                     exp_beats_i,
    input  int                     exp_wlast_i,
    output int                     err_cnt_o,
    output int                     test_cnt_o
);

    logic [63:0] ref_mem [int];
    int  if_cnt, mem_cnt, wr_cnt, beats, wlasts, test_errs;
    logic any_req;

    function automatic logic [63:0] ref_word(int idx);
        logic [31:0] a;
        a = idx << 3;
        return ref_mem.exists(idx) ? ref_mem[idx] : {~a, a};
    endfunction

    // 2^size lanes from the byte offset of this beat
    function automatic logic [7:0] lanes(logic [31:0] baddr, logic [2:0] size);
        logic [7:0] m;
        m = '0;
        for (int k = 0; k < (1 << size); k++) begin
            if (baddr[2:0] + k < 8) m[baddr[2:0] + k] = 1'b1;
        end
        return m;
    endfunction

    task automatic fail(string msg);
        $display("Fail %0t: %s", $time, msg);
        err_cnt_o++;
        test_errs++;
    endtask

    initial begin
        {if_cnt, mem_cnt, wr_cnt, beats, wlasts, test_errs, err_cnt_o, test_cnt_o} = '0;
        any_req = 1'b0;
    end

    always @(negedge clk) begin
        logic [31:0] baddr;
        logic [7:0]  m;
        logic [63:0] w;
        if (!rst) begin
            if (!any_req && (arvalid_o || awvalid_o || wvalid_o || bready_o || rready_o ||
                    if_ar_ready_o || if_ar_last_o || mem_r_ready_o || mem_r_last_o ||
                    mem_w_ready_o || mem_w_last_o)) begin
                $display("bus activity seen at %0t before any request", $time);
                err_cnt_o++;
            end
            any_req = any_req || if_ar_valid_i || mem_r_valid_i || mem_w_valid_i;
            if (!mem_r_valid_i && (mem_r_ready_o || mem_r_last_o || mem_r_data_o != 0))
                fail("MEM read outputs not zero while idle");
            if (!if_ar_valid_i && (if_ar_ready_o || if_ar_last_o || if_ar_data_o != 0))
                fail("IF read outputs not zero while idle");
            // MEM owns the read path whenever it asks
            if (arvalid_o && arready_i) begin
                if (araddr_o !== (mem_r_valid_i ? mem_r_addr_i : if_ar_addr_i) ||
                        arlen_o !== (mem_r_valid_i ? mem_r_len_i : if_ar_len_i))
                    fail($sformatf("AR addr %h len %0d", araddr_o, arlen_o));
                if (arsize_o !== `BEAT_SIZE_8B || arburst_o !== 2'b01 || arid_o !== `RD_ID)
                    fail($sformatf("AR size %0d burst %b id %0d", arsize_o, arburst_o, arid_o));
            end
            if (awvalid_o && awready_i) begin
                if (awaddr_o !== mem_w_addr_i || awlen_o !== mem_w_len_i ||
                        awsize_o !== mem_w_size_i)
                    fail($sformatf("AW addr %h len %0d size %0d", awaddr_o, awlen_o, awsize_o));
                if (awburst_o !== 2'b01 || awid_o !== `WR_ID)  // INCR
                    fail($sformatf("AW burst %b id %0d", awburst_o, awid_o));
            end
            if (mem_r_ready_o) begin
                if (mem_r_data_o !== ref_word((mem_r_addr_i >> 3) + mem_cnt))
                    fail($sformatf("MEM beat %0d data %h", mem_cnt, mem_r_data_o));
                if (mem_r_last_o !== (mem_cnt == mem_r_len_i))
                    fail($sformatf("MEM last wrong on beat %0d", mem_cnt));
                mem_cnt = mem_r_last_o ? 0 : mem_cnt + 1;
                beats++;
            end
            if (if_ar_ready_o) begin
                if (mem_r_valid_i) fail("IF beat while MEM read pending");
                if (if_ar_data_o !== ref_word((if_ar_addr_i >> 3) + if_cnt))
                    fail($sformatf("IF beat %0d data %h", if_cnt, if_ar_data_o));
                if (if_ar_last_o !== (if_cnt == if_ar_len_i))
                    fail($sformatf("IF last wrong on beat %0d", if_cnt));
                if_cnt = if_ar_last_o ? 0 : if_cnt + 1;
                beats++;
            end
            if (mem_w_ready_o) begin
                baddr = mem_w_addr_i + (wr_cnt << mem_w_size_i);
                m = lanes(baddr, mem_w_size_i);
                if (wstrb_o !== m)
                    fail($sformatf("wstrb %b on beat %0d, expected %b", wstrb_o, wr_cnt, m));
                if (wlast_o !== (wr_cnt == mem_w_len_i))
                    fail($sformatf("wlast wrong on beat %0d", wr_cnt));
                w = ref_word(baddr >> 3);
                for (int b = 0; b < 8; b++) begin
                    if (m[b]) w[b*8 +: 8] = mem_w_data_i[b*8 +: 8];
                end
                ref_mem[baddr >> 3] = w;
                wr_cnt++;
                beats++;
            end
            if (mem_w_last_o) begin
                wlasts++;
                wr_cnt = 0;
            end
            if (test_done_i) begin
                if (beats != exp_beats_i || wlasts != exp_wlast_i) begin
                    $display("test %0d: %0d beats and %0d write ends, expected %0d and %0d",
                             test_idx_i, beats, wlasts, exp_beats_i, exp_wlast_i);
                    err_cnt_o++;
                end else begin
                    $display("test %0d: %0d beats, %0d errors", test_idx_i, beats, test_errs);
                end
                test_cnt_o++;
                {beats, wlasts, test_errs} = '0;
            end
        end
    end

endmodule

//--- verif/tb_top.sv
`timescale 1ns/1ps
`include "cpu_axi_settings.svh"

module tb_top;

    localparam int N_ROWS = 8;
    localparam int K_IF   = 0;
    localparam int K_MEMR = 1;
    localparam int K_BOTH = 2;     // MEM at addr, IF at addr + 0x100
    localparam int K_MEMW = 3;

    logic clk, rst;
    logic if_ar_valid_i, if_ar_ready_o, if_ar_last_o;
    logic [`AXI_ADDR_W-1:0] if_ar_addr_i, mem_r_addr_i, mem_w_addr_i, araddr_o, awaddr_o;
    logic [`AXI_LEN_W-1:0]  if_ar_len_i, mem_r_len_i, mem_w_len_i, arlen_o, awlen_o;
    logic [`AXI_DATA_W-1:0] if_ar_data_o, mem_r_data_o, mem_w_data_i, rdata_i, wdata_o;
    logic mem_r_valid_i, mem_r_ready_o, mem_r_last_o;
    logic mem_w_valid_i, mem_w_ready_o, mem_w_last_o;
    logic [2:0] mem_w_size_i, arsize_o, awsize_o;
    logic [1:0] arburst_o, awburst_o;
    logic [`AXI_ID_W-1:0] arid_o, awid_o;
    logic arvalid_o, arready_i, rlast_i, rvalid_i, rready_o;
    logic awvalid_o, awready_i, wlast_o, wvalid_o, wready_i, bvalid_i, bready_o;
    logic [`AXI_STRB_W-1:0] wstrb_o;

    logic test_done_i;
    int   test_idx_i, exp_beats_i, exp_wlast_i, err_cnt_o, test_cnt_o;
    int   cycles, limit;

    // stimulus table
    int          kind_t  [N_ROWS] = '{K_IF, K_MEMR, K_BOTH, K_MEMW, K_MEMR, K_MEMW, K_MEMR, K_IF};
    logic [31:0] addr_t  [N_ROWS] = '{32'h100, 32'h200, 32'h300, 32'h300,
                                      32'h300, 32'h305, 32'h300, 32'h300};
    int          len_t   [N_ROWS] = '{3, 1, 2, 3, 3, 0, 0, 7};
    logic [2:0]  size_t  [N_ROWS] = '{3, 3, 3, 3, 3, 0, 3, 3};
    logic [31:0] seed_t  [N_ROWS] = '{0, 0, 0, 32'h1111_2222, 0, 32'h0000_00a5, 0, 0};
    int          beats_t [N_ROWS] = '{4, 2, 6, 4, 4, 1, 1, 8};

    cpu_axi_top DUT (.*);
    axi_mem_model u_mem (.*);
    tb_checker u_chk (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= limit) begin
            $display("run timed out after %0d cycles", cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // one data word per beat
    function automatic logic [63:0] beat_word(logic [31:0] seed, logic [2:0] size, int beat);
        if (size == 3'd0) begin
            return {8{seed[7:0]}};  // byte copied to all lanes
        end
        return {~(seed + beat), seed + beat * 32'h0101_0101};
    endfunction

    task automatic read_if(logic [31:0] addr, int len);
        if_ar_valid_i = 1'b1;
        if_ar_addr_i  = addr;
        if_ar_len_i   = len;
        @(negedge clk);
        while (!if_ar_last_o) @(negedge clk);
        @(posedge clk);
        #1 if_ar_valid_i = 1'b0;
    endtask

    task automatic read_mem(logic [31:0] addr, int len);
        mem_r_valid_i = 1'b1;
        mem_r_addr_i  = addr;
        mem_r_len_i   = len;
        @(negedge clk);
        while (!mem_r_last_o) @(negedge clk);
        @(posedge clk);
        #1 mem_r_valid_i = 1'b0;
    endtask

    task automatic write_mem(logic [31:0] addr, int len, logic [2:0] size, logic [31:0] seed);
        int beat;
        beat          = 0;
        mem_w_valid_i = 1'b1;
        mem_w_addr_i  = addr;
        mem_w_len_i   = len;
        mem_w_size_i  = size;
        mem_w_data_i  = beat_word(seed, size, 0);
        @(negedge clk);
        while (!mem_w_last_o) begin
            if (mem_w_ready_o) begin
                beat++;
                @(posedge clk);
                #1 mem_w_data_i = beat_word(seed, size, beat);
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1 mem_w_valid_i = 1'b0;
    endtask

    initial begin
        void'($urandom(36982));
        {if_ar_valid_i, mem_r_valid_i, mem_w_valid_i, test_done_i} = '0;
        {if_ar_addr_i, mem_r_addr_i, mem_w_addr_i} = '0;
        {if_ar_len_i, mem_r_len_i, mem_w_len_i, mem_w_size_i} = '0;
        mem_w_data_i = '0;
        {test_idx_i, exp_beats_i, exp_wlast_i} = '0;
        cycles = 0;
        limit  = 200;
        for (int i = 0; i < N_ROWS; i++) limit += (len_t[i] + 1) * 8;
        rst = 1'b1;
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;
        repeat (3) @(posedge clk);  // idle time for the post-reset check
        for (int i = 0; i < N_ROWS; i++) begin
            #1;
            case (kind_t[i])
                K_IF:   read_if(addr_t[i], len_t[i]);
                K_MEMR: read_mem(addr_t[i], len_t[i]);
                K_BOTH: fork
                    read_mem(addr_t[i], len_t[i]);
                    read_if(addr_t[i] + 32'h100, len_t[i]);
                join
                default: write_mem(addr_t[i], len_t[i], size_t[i], seed_t[i]);
            endcase
            @(posedge clk);
            #1;
            test_idx_i  = i;
            exp_beats_i = beats_t[i];
            exp_wlast_i = (kind_t[i] == K_MEMW);
            test_done_i = 1'b1;
            @(posedge clk);
            #1 test_done_i = 1'b0;
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        $display("tests run %0d of %0d, errors %0d", test_cnt_o, N_ROWS, err_cnt_o);
        if (err_cnt_o == 0 && test_cnt_o == N_ROWS) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+hw
hw/cpu_axi_pkg.sv
hw/axi_rw_if.sv
hw/mem_bus_arbiter.sv
hw/axi_read_master.sv
hw/axi_write_master.sv
hw/cpu_axi_top.sv
verif/axi_mem_model.sv
verif/tb_checker.sv
verif/tb_top.sv
